/* all.f */
common/sd_tx_pkg.sv
sd_sender/crc7_gen.sv
sd_sender/crc16_gen.sv
sd_sender/sd_frame_sender.sv
hdl/sd_tx_top.sv
sim/sd_tx_chk.sv
sim/sd_tx_tb.sv

/* common/sd_tx_pkg.sv */
// ##########################################################
// Shared definitions for the SD SPI transmit path
// Frame lengths, CRC widths, start token, counter width
// Enums for sender state and frame kind
// ##########################################################

`default_nettype none

package sd_tx_pkg;

  // Command frame layout
  localparam int CMD_CRC_START = 40;
  localparam int CRC7_BITS     = 7;
  localparam int CMD_BITS      = CMD_CRC_START + CRC7_BITS + 1;
  // Bits left in a command frame once the CRC7 begins (CRC7 plus end bit)
  localparam int CMD_TAIL_BITS = CRC7_BITS + 1;

  // Data block frame layout
  localparam int TOKEN_BITS      = 8;
  localparam int DATA_BITS       = 4096;
  localparam int CRC16_BITS      = 16;
  localparam int DATA_FRAME_BITS = TOKEN_BITS + DATA_BITS + CRC16_BITS;
  // Counter value on the first data bit after the token
  localparam int DATA_CRC_START  = DATA_FRAME_BITS - TOKEN_BITS;

  localparam logic [TOKEN_BITS-1:0] START_TOKEN = 8'hFE;

  // Frame shift register holds token and data
  localparam int SREG_W = TOKEN_BITS + DATA_BITS;
  localparam int CNT_W  = 13;

  typedef enum logic {KIND_CMD, KIND_DATA} frame_kind_t;
  typedef enum logic {ST_IDLE, ST_SEND} sender_state_t;

endpackage

`default_nettype wire

/* hdl/sd_tx_top.sv */
// ##########################################################
// SD SPI transmit path top level
// Frame sender with CRC7 and CRC16 generators
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module sd_tx_top
  import sd_tx_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  frame_kind_t          kind,
  input  logic [5:0]           cmd_index,
  input  logic [31:0]          argument,
  input  logic [DATA_BITS-1:0] data,
  output logic                 ready,
  output logic                 mosi
);

  logic payload_bit;
  logic crc_clear;
  logic crc7_feed;
  logic crc7_shift;
  logic crc16_feed;
  logic crc16_shift;
  logic crc7_bit;
  logic crc16_bit;

  sd_frame_sender sender_i (
    .clock       (clock),
    .reset       (reset),
    .valid       (valid),
    .kind        (kind),
    .cmd_index   (cmd_index),
    .argument    (argument),
    .data        (data),
    .crc7_bit    (crc7_bit),
    .crc16_bit   (crc16_bit),
    .ready       (ready),
    .mosi        (mosi),
    .payload_bit (payload_bit),
    .crc_clear   (crc_clear),
    .crc7_feed   (crc7_feed),
    .crc7_shift  (crc7_shift),
    .crc16_feed  (crc16_feed),
    .crc16_shift (crc16_shift)
  );

  // Command checksum
  crc7_gen crc7_i (
    .clock       (clock),
    .reset       (reset),
    .clear       (crc_clear),
    .feed        (crc7_feed),
    .shift       (crc7_shift),
    .payload_bit (payload_bit),
    .crc_bit     (crc7_bit)
  );

  // Data block checksum
  crc16_gen crc16_i (
    .clock       (clock),
    .reset       (reset),
    .clear       (crc_clear),
    .feed        (crc16_feed),
    .shift       (crc16_shift),
    .payload_bit (payload_bit),
    .crc_bit     (crc16_bit)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the SD transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module sd_tx_tb \
  -f all.f \
  -o sd_tx_sim

./obj_dir/sd_tx_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation OK"
  exit 0
else
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

/* sd_sender/crc16_gen.sv */
// ##########################################################
// CRC16 CCITT generator, polynomial x^16 + x^12 + x^5 + 1
// Serial LFSR over the data bits, zero initial value,
// remainder shifted out MSB first
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module crc16_gen
  import sd_tx_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic feed,
  input  logic shift,
  input  logic payload_bit,
  output logic crc_bit
);

  logic [CRC16_BITS-1:0] crc;
  logic                  fb;

  assign fb      = crc[CRC16_BITS-1] ^ payload_bit;
  assign crc_bit = crc[CRC16_BITS-1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      crc <= '0;
    end else if (clear) begin
      crc <= '0;
    end else if (feed) begin
      // Feedback into bits 12, 5 and 0
      crc <= {crc[14:12],
              crc[11] ^ fb,
              crc[10:5],
              crc[4] ^ fb,
              crc[3:0],
              fb};
    end else if (shift) begin
      crc <= {crc[CRC16_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* sd_sender/crc7_gen.sv */
// ##########################################################
// CRC7 generator, polynomial x^7 + x^3 + 1
// Serial LFSR with remainder shift-out
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module crc7_gen
  import sd_tx_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic clear,
  input  logic feed,
  input  logic shift,
  input  logic payload_bit,
  output logic crc_bit
);

  logic [CRC7_BITS-1:0] crc;
  logic                 fb;

  assign fb      = crc[CRC7_BITS-1] ^ payload_bit;
  assign crc_bit = crc[CRC7_BITS-1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      crc <= '0;
    end else if (clear) begin
      crc <= '0;
    end else if (feed) begin
      // Taps at x^3 and x^0
      crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    end else if (shift) begin
      crc <= {crc[CRC7_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* sd_sender/sd_frame_sender.sv */
// ##########################################################
// Frame sender for the SD SPI transmit path
// FSM, bit down-counter, frame shift register,
// CRC strobe decode and mosi source select
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module sd_frame_sender
  import sd_tx_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  frame_kind_t          kind,
  input  logic [5:0]           cmd_index,
  input  logic [31:0]          argument,
  input  logic [DATA_BITS-1:0] data,
  input  logic                 crc7_bit,
  input  logic                 crc16_bit,
  output logic                 ready,
  output logic                 mosi,
  output logic                 payload_bit,
  output logic                 crc_clear,
  output logic                 crc7_feed,
  output logic                 crc7_shift,
  output logic                 crc16_feed,
  output logic                 crc16_shift
);

  sender_state_t     state;
  frame_kind_t       kind_q;
  logic [CNT_W-1:0]  count;
  logic [SREG_W-1:0] shreg;
  logic              accept;
  logic              sending;
  logic              last_bit;
  logic              is_cmd;

  assign ready    = (state == ST_IDLE);
  assign sending  = (state == ST_SEND);
  assign accept   = ready & valid;
  assign last_bit = sending && (count == CNT_W'(1));
  assign is_cmd   = (kind_q == KIND_CMD);

  // Generators clear on the accepting edge itself
  assign crc_clear   = accept;
  assign payload_bit = shreg[SREG_W-1];

  // Control state and bits remaining
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state  <= ST_IDLE;
      kind_q <= KIND_CMD;
      count  <= '0;
    end else if (accept) begin
      state  <= ST_SEND;
      kind_q <= kind;
      if (kind == KIND_DATA) begin
        count <= CNT_W'(DATA_FRAME_BITS);
      end else begin
        count <= CNT_W'(CMD_BITS);
      end
    end else if (sending) begin
      count <= count - 1'b1;
      if (last_bit) begin
        state <= ST_IDLE;
      end
    end
  end

  // Payload register, MSB goes out first
  always_ff @(posedge clock) begin
    if (accept) begin
      if (kind == KIND_DATA) begin
        shreg <= {START_TOKEN, data};
      end else begin
        // Start bit, transmission bit, index, argument, ones behind
        shreg <= {1'b0, 1'b1, cmd_index, argument, {(SREG_W-CMD_CRC_START){1'b1}}};
      end
    end else if (sending) begin
      shreg <= {shreg[SREG_W-2:0], 1'b1};
    end
  end

  // CRC7 covers the first 40 command bits, then shifts out 7 bits
  assign crc7_feed  = sending && is_cmd && (count > CNT_W'(CMD_TAIL_BITS));
  assign crc7_shift = sending && is_cmd && (count <= CNT_W'(CMD_TAIL_BITS)) &&
                      (count > CNT_W'(1));

  // CRC16 skips the token and covers the data bits only
  assign crc16_feed  = sending && !is_cmd && (count > CNT_W'(CRC16_BITS)) &&
                       (count <= CNT_W'(DATA_CRC_START));
  assign crc16_shift = sending && !is_cmd && (count <= CNT_W'(CRC16_BITS));

  // Line source select
  always_comb begin
    if (!sending) begin
      mosi = 1'b1;
    end else if (is_cmd) begin
      if (crc7_shift) begin
        mosi = crc7_bit;
      end else if (last_bit) begin
        // End bit
        mosi = 1'b1;
      end else begin
        mosi = payload_bit;
      end
    end else begin
      if (crc16_shift) begin
        mosi = crc16_bit;
      end else begin
        mosi = payload_bit;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/sd_tx_chk.sv */
// ##########################################################
// Concurrent assertions on the frame sender
// Idle line, CRC clear timing, strobe exclusion
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module sd_tx_chk
  import sd_tx_pkg::*;
(
  input logic          clock,
  input logic          reset,
  input sender_state_t state,
  input logic          ready,
  input logic          mosi,
  input logic          crc_clear,
  input logic          crc7_feed,
  input logic          crc7_shift,
  input logic          crc16_feed,
  input logic          crc16_shift
);

  idle_high_a: assert property (@(posedge clock) disable iff (reset)
    ready |-> mosi)
    else $error("mosi low while the sender is ready");

  // Clear only on the edge that moves the FSM from idle into a frame
  clear_on_accept_a: assert property (@(posedge clock) disable iff (reset)
    crc_clear |=> (($past(state) == ST_IDLE) && (state == ST_SEND)))
    else $error("crc_clear high outside an accepting edge");

  // Feed and shift of one generator never overlap
  crc7_excl_a: assert property (@(posedge clock) disable iff (reset)
    !(crc7_feed && crc7_shift))
    else $error("CRC7 fed and shifted in the same cycle");

  crc16_excl_a: assert property (@(posedge clock) disable iff (reset)
    !(crc16_feed && crc16_shift))
    else $error("CRC16 fed and shifted in the same cycle");

endmodule

bind sd_frame_sender sd_tx_chk chk_i (
  .clock       (clock),
  .reset       (reset),
  .state       (state),
  .ready       (ready),
  .mosi        (mosi),
  .crc_clear   (crc_clear),
  .crc7_feed   (crc7_feed),
  .crc7_shift  (crc7_shift),
  .crc16_feed  (crc16_feed),
  .crc16_shift (crc16_shift)
);

`default_nettype wire

/* sim/sd_tx_tb.sv */
// ##########################################################
// Testbench for the SD SPI transmit path
// Random command and data frames, serial CRC model,
// bit-by-bit mosi compare, idle line checks, cycle timeout
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module sd_tx_tb
  import sd_tx_pkg::*;
;

  localparam logic [31:0] SEED           = 32'h5786_3f42;
  localparam logic [6:0]  CRC7_POLY      = 7'h09;
  localparam logic [15:0] CRC16_POLY     = 16'h1021;
  // About 17000 cycles of frames (4 data, 10 command) plus margin
  localparam int          TIMEOUT_CYCLES = 20000;

  logic                 clock = 1'b0;
  logic                 reset;
  logic                 valid;
  frame_kind_t          kind;
  logic [5:0]           cmd_index;
  logic [31:0]          argument;
  logic [DATA_BITS-1:0] data;
  logic                 ready;
  logic                 mosi;

  logic exp_bits [DATA_FRAME_BITS];
  int   exp_len;
  int   test_errors;
  int   pass_count = 0;
  int   fail_count = 0;
  int   cycles = 0;

  sd_tx_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .valid     (valid),
    .kind      (kind),
    .cmd_index (cmd_index),
    .argument  (argument),
    .data      (data),
    .ready     (ready),
    .mosi      (mosi)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a frame never completed", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Start bit, transmission bit, index, argument, CRC7, end bit
  function automatic void build_cmd_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [CMD_CRC_START-1:0] head;
    logic [6:0]               crc;
    logic                     fb;
    int                       i;
    head = {1'b0, 1'b1, idx, arg};
    crc  = '0;
    for (i = 0; i < CMD_CRC_START; i++) begin
      exp_bits[i] = head[CMD_CRC_START-1-i];
      fb  = crc[6] ^ head[CMD_CRC_START-1-i];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ CRC7_POLY;
      end
    end
    for (i = 0; i < 7; i++) begin
      exp_bits[CMD_CRC_START+i] = crc[6-i];
    end
    exp_bits[CMD_BITS-1] = 1'b1;
    exp_len = CMD_BITS;
  endfunction

  // Token FE, data MSB first, CRC16 over the data only
  function automatic void build_data_frame(input logic [DATA_BITS-1:0] blk);
    logic [15:0] crc;
    logic        fb;
    int          i;
    for (i = 0; i < 8; i++) begin
      exp_bits[i] = START_TOKEN[7-i];
    end
    crc = '0;
    for (i = 0; i < DATA_BITS; i++) begin
      exp_bits[8+i] = blk[DATA_BITS-1-i];
      fb  = crc[15] ^ blk[DATA_BITS-1-i];
      crc = {crc[14:0], 1'b0};
      if (fb) begin
        crc = crc ^ CRC16_POLY;
      end
    end
    for (i = 0; i < 16; i++) begin
      exp_bits[8+DATA_BITS+i] = crc[15-i];
    end
    exp_len = DATA_FRAME_BITS;
  endfunction

  task automatic random_block(output logic [DATA_BITS-1:0] blk);
    int w;
    for (w = 0; w < DATA_BITS / 32; w++) begin
      blk[w*32 +: 32] = $urandom;
    end
  endtask

  // Starts and ends just after a rising edge
  task automatic check_idle(input string name, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(negedge clock);
      if (ready !== 1'b1 || mosi !== 1'b1) begin
        $display("error: %s idle line expected ready 1 mosi 1 actual ready %b mosi %b",
                 name, ready, mosi);
        test_errors++;
      end
      @(posedge clock);
      #1;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s (%0d errors)", name, test_errors);
    end
  endtask

  task automatic run_frame(input string name, input frame_kind_t fk, input logic [5:0] idx,
                           input logic [31:0] arg, input logic [DATA_BITS-1:0] blk,
                           input bit back_to_back, input bit keep_valid, input bit disturb);
    int i;
    test_errors = 0;
    if (fk == KIND_DATA) begin
      build_data_frame(blk);
    end else begin
      build_cmd_frame(idx, arg);
    end
    valid     = 1'b1;
    kind      = fk;
    cmd_index = idx;
    argument  = arg;
    data      = blk;
    @(negedge clock);
    if (back_to_back && (ready !== 1'b1 || mosi !== 1'b1)) begin
      $display("error: %s after previous frame expected ready 1 mosi 1 actual ready %b mosi %b",
               name, ready, mosi);
      test_errors++;
    end
    while (ready !== 1'b1) begin
      @(negedge clock);
    end
    // Accepting edge
    @(posedge clock);
    #1;
    if (!keep_valid) begin
      valid = 1'b0;
    end
    for (i = 0; i < exp_len; i++) begin
      @(negedge clock);
      if (mosi !== exp_bits[i]) begin
        $display("error: %s bit %0d expected %b actual %b", name, i, exp_bits[i], mosi);
        test_errors++;
      end
      if (ready !== 1'b0) begin
        $display("error: %s ready at bit %0d expected 0 actual %b", name, i, ready);
        test_errors++;
      end
      @(posedge clock);
      #1;
      if (disturb) begin
        // New request with other kind and fields mid-frame
        if (i >= exp_len / 2 && i < exp_len / 2 + 4) begin
          valid     = 1'b1;
          cmd_index = 6'($urandom);
          argument  = $urandom;
          data      = ~blk;
          if (fk == KIND_CMD) begin
            kind = KIND_DATA;
          end else begin
            kind = KIND_CMD;
          end
        end else begin
          valid = 1'b0;
        end
      end
    end
    if (!keep_valid) begin
      check_idle(name, 2);
    end
    finish_test(name);
  endtask

  initial begin
    int                   n;
    logic [DATA_BITS-1:0] blk;
    reset     = 1'b1;
    valid     = 1'b0;
    kind      = KIND_CMD;
    cmd_index = '0;
    argument  = '0;
    data      = '0;
    void'($urandom(SEED));
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;

    test_errors = 0;
    check_idle("idle_after_reset", 3);
    finish_test("idle_after_reset");

    for (n = 0; n < 8; n++) begin
      run_frame($sformatf("cmd_%0d", n), KIND_CMD, 6'($urandom), $urandom, '0, 0, 0, 0);
    end

    for (n = 0; n < 3; n++) begin
      random_block(blk);
      run_frame($sformatf("data_%0d", n), KIND_DATA, '0, '0, blk, 0, 0, 0);
    end

    run_frame("busy_ignored", KIND_CMD, 6'($urandom), $urandom, '0, 0, 0, 1);

    // Valid stays high from the command into the data block
    random_block(blk);
    run_frame("b2b_cmd", KIND_CMD, 6'($urandom), $urandom, '0, 0, 1, 0);
    run_frame("b2b_data", KIND_DATA, '0, '0, blk, 1, 0, 0);

    $display("Summary: %0d passing, %0d failing", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
